/* cpuPkg.sv */
package cpuPkg;

	// ==================================================
	// basic words
	// ==================================================
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	// top six bits of the instruction
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// r-type function field
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2a
	} funct_e;

	// lui passes the pre-shifted immediate through
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI
	} aluOp_e;

	// execute operand source
	typedef enum logic [1:0] {
		FWD_REGFILE,
		FWD_MEM,
		FWD_WB
	} forwardSel_e;

	// ==================================================
	// control carried down the pipe
	// ==================================================
	// valid is low for bubbles and for the empty slot after reset
	typedef struct packed {
		logic     valid;
		aluOp_e   aluOp;
		logic     aluSrcImm;
		logic     regWrite;
		logic     memToReg;
		logic     memWrite;
		regAddr_t writeReg;
	} ctrl_t;

endpackage

/* hazardIf.sv */
`timescale 1ns/1ns

interface hazardIf;

	// decode side
	cpuPkg::regAddr_t rsD;
	cpuPkg::regAddr_t rtD;
	logic branchD;
	logic stallD;
	logic stallF;
	logic flushE;
	// one bit each, take the memory-stage alu result
	logic forwardAD;
	logic forwardBD;

	// execute side
	cpuPkg::regAddr_t rsE;
	cpuPkg::regAddr_t rtE;
	cpuPkg::regAddr_t writeRegE;
	logic regWriteE;
	logic memToRegE;
	cpuPkg::forwardSel_e forwardAE;
	cpuPkg::forwardSel_e forwardBE;

	// memory and writeback destinations
	cpuPkg::regAddr_t writeRegM;
	logic regWriteM;
	logic memToRegM;
	cpuPkg::regAddr_t writeRegW;
	logic regWriteW;

	modport fetch (input stallF);
	modport decode (output rsD, rtD, branchD, input stallD, flushE, forwardAD, forwardBD);
	modport execute (output rsE, rtE, writeRegE, regWriteE, memToRegE,
		input forwardAE, forwardBE);
	modport memWb (output writeRegM, regWriteM, memToRegM, writeRegW, regWriteW);
	modport hazard (input rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE,
		writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE);

endinterface

/* fetchStage.sv */
`timescale 1ns/1ns

module fetchStage #(
	parameter cpuPkg::word_t resetVector = 32'h0
) (
	input logic clk,
	input logic reset,
	input cpuPkg::word_t instr,
	input logic branchTaken,
	input cpuPkg::word_t branchTarget,
	hazardIf.fetch hz,
	output cpuPkg::word_t instrAddr,
	output cpuPkg::word_t instrD,
	output cpuPkg::word_t pcD,
	output cpuPkg::word_t pcPlus4D
);

	cpuPkg::word_t pc;
	cpuPkg::word_t pcPlus4F;

	assign instrAddr = pc;
	assign pcPlus4F = pc + 32'd4;

	// branch resolves in decode, so the delay slot is already being fetched
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetVector;
		end else if (!hz.stallF) begin
			pc <= branchTaken ? branchTarget : pcPlus4F;
		end
	end

	// fetch/decode register
	// instr clears to sll r0 which decodes as a no-op
	always_ff @(posedge clk) begin
		if (reset) begin
			instrD <= '0;
		end else if (!hz.stallF) begin
			instrD <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!hz.stallF) begin
			pcD <= pc;
			pcPlus4D <= pcPlus4F;
		end
	end

endmodule

/* regFile.sv */
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic reset,
	input cpuPkg::regAddr_t rs,
	input cpuPkg::regAddr_t rt,
	input cpuPkg::regAddr_t writeReg,
	input logic writeEn,
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t rsData,
	output cpuPkg::word_t rtData
);

	// register 0 has no storage
	cpuPkg::word_t regs [31:1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeReg != 5'd0) begin
			regs[writeReg] <= writeData;
		end
	end

	// writeback in the same cycle wins over the stored value
	assign rsData = (rs == 5'd0) ? '0 : (writeEn && writeReg == rs) ? writeData : regs[rs];
	assign rtData = (rt == 5'd0) ? '0 : (writeEn && writeReg == rt) ? writeData : regs[rt];

endmodule

/* decodeStage.sv */
`timescale 1ns/1ns

module decodeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::word_t instrD,
	input cpuPkg::word_t pcD,
	input cpuPkg::word_t pcPlus4D,
	input cpuPkg::word_t aluOutM,
	input cpuPkg::word_t resultW,
	input logic regWriteW,
	input cpuPkg::regAddr_t writeRegW,
	hazardIf.decode hz,
	output logic branchTaken,
	output cpuPkg::word_t branchTarget,
	output cpuPkg::ctrl_t ctrlE,
	output cpuPkg::word_t srcAE,
	output cpuPkg::word_t srcBE,
	output cpuPkg::word_t immE,
	output cpuPkg::word_t pcE,
	output cpuPkg::regAddr_t rsE,
	output cpuPkg::regAddr_t rtE
);

	cpuPkg::opcode_e op;
	cpuPkg::funct_e fn;
	cpuPkg::word_t rsData, rtData, immD, cmpA, cmpB;
	cpuPkg::ctrl_t ctrlD;
	logic validD;

	assign op = cpuPkg::opcode_e'(instrD[31:26]);
	assign fn = cpuPkg::funct_e'(instrD[5:0]);
	assign hz.rsD = instrD[25:21];
	assign hz.rtD = instrD[20:16];

	regFile i_regFile (.clk(clk), .reset(reset), .rs(hz.rsD), .rt(hz.rtD), .writeReg(writeRegW),
		.writeEn(regWriteW), .writeData(resultW), .rsData(rsData), .rtData(rtData));

	// fetch/decode register is empty until the first fetch lands
	always_ff @(posedge clk) begin
		if (reset) begin
			validD <= 1'b0;
		end else if (!hz.stallD) begin
			validD <= 1'b1;
		end
	end

	// ==================================================
	// decoder
	// ==================================================
	// writeReg carries rd, execute swaps in rt for immediate forms
	always_comb begin
		ctrlD = '0;
		ctrlD.aluOp = cpuPkg::ALU_ADD;
		ctrlD.writeReg = instrD[15:11];
		case (op)
			cpuPkg::OP_SPECIAL: begin
				ctrlD.regWrite = 1'b1;
				case (fn)
					cpuPkg::FN_ADDU: ctrlD.aluOp = cpuPkg::ALU_ADD;
					cpuPkg::FN_SUBU: ctrlD.aluOp = cpuPkg::ALU_SUB;
					cpuPkg::FN_AND:  ctrlD.aluOp = cpuPkg::ALU_AND;
					cpuPkg::FN_OR:   ctrlD.aluOp = cpuPkg::ALU_OR;
					cpuPkg::FN_SLT:  ctrlD.aluOp = cpuPkg::ALU_SLT;
					// unknown funct, no-op
					default: ctrlD.regWrite = 1'b0;
				endcase
			end
			cpuPkg::OP_ADDIU: begin
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.regWrite = 1'b1;
			end
			cpuPkg::OP_ORI: begin
				ctrlD.aluOp = cpuPkg::ALU_OR;
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.regWrite = 1'b1;
			end
			cpuPkg::OP_LUI: begin
				ctrlD.aluOp = cpuPkg::ALU_LUI;
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.regWrite = 1'b1;
			end
			cpuPkg::OP_LW: begin
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.regWrite = 1'b1;
				ctrlD.memToReg = 1'b1;
			end
			cpuPkg::OP_SW: begin
				ctrlD.aluSrcImm = 1'b1;
				ctrlD.memWrite = 1'b1;
			end
			// branches and unknown opcodes write nothing
			default: ctrlD.aluSrcImm = 1'b1;
		endcase
		ctrlD.valid = validD;
		if (!validD) begin
			ctrlD.regWrite = 1'b0;
			ctrlD.memWrite = 1'b0;
		end
	end

	// immediate, zero for ori, pre-shifted for lui, else sign
	always_comb begin
		case (op)
			cpuPkg::OP_ORI: immD = {16'h0, instrD[15:0]};
			cpuPkg::OP_LUI: immD = {instrD[15:0], 16'h0};
			default: immD = {{16{instrD[15]}}, instrD[15:0]};
		endcase
	end

	// ==================================================
	// early branch
	// ==================================================
	// writeback is covered by the regfile bypass
	assign cmpA = hz.forwardAD ? aluOutM : rsData;
	assign cmpB = hz.forwardBD ? aluOutM : rtData;
	assign hz.branchD = validD && (op == cpuPkg::OP_BEQ || op == cpuPkg::OP_BNE);
	// operands not ready while stalled
	assign branchTaken = hz.branchD && !hz.stallD &&
		((op == cpuPkg::OP_BEQ) ? (cmpA == cmpB) : (cmpA != cmpB));
	assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};

	// decode/execute register, bubble on flush
	always_ff @(posedge clk) begin
		if (reset || hz.flushE) begin
			ctrlE <= '0;
		end else begin
			ctrlE <= ctrlD;
		end
	end

	always_ff @(posedge clk) begin
		srcAE <= rsData;
		srcBE <= rtData;
		immE <= immD;
		pcE <= pcD;
		rsE <= hz.rsD;
		rtE <= hz.rtD;
	end

endmodule

/* executeStage.sv */
`timescale 1ns/1ns

module executeStage (
	input logic clk,
	input logic reset,
	input cpuPkg::ctrl_t ctrlE,
	input cpuPkg::word_t srcAE,
	input cpuPkg::word_t srcBE,
	input cpuPkg::word_t immE,
	input cpuPkg::word_t pcE,
	input cpuPkg::regAddr_t rsE,
	input cpuPkg::regAddr_t rtE,
	input cpuPkg::word_t resultW,
	hazardIf.execute hz,
	output cpuPkg::ctrl_t ctrlM,
	output cpuPkg::word_t aluOutM,
	output cpuPkg::word_t storeDataM,
	output cpuPkg::word_t pcM
);

	cpuPkg::word_t srcA, srcB, aluB, aluResult;
	cpuPkg::regAddr_t writeRegE;
	cpuPkg::ctrl_t ctrlX;

	// same mux for both operands
	function automatic cpuPkg::word_t pickOperand(
		input cpuPkg::forwardSel_e sel,
		input cpuPkg::word_t regVal,
		input cpuPkg::word_t memVal,
		input cpuPkg::word_t wbVal
	);
		case (sel)
			cpuPkg::FWD_MEM: return memVal;
			cpuPkg::FWD_WB:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	assign srcA = pickOperand(hz.forwardAE, srcAE, aluOutM, resultW);
	assign srcB = pickOperand(hz.forwardBE, srcBE, aluOutM, resultW);
	assign aluB = ctrlE.aluSrcImm ? immE : srcB;

	// ==================================================
	// alu
	// ==================================================
	always_comb begin
		case (ctrlE.aluOp)
			cpuPkg::ALU_SUB: aluResult = srcA - aluB;
			cpuPkg::ALU_AND: aluResult = srcA & aluB;
			cpuPkg::ALU_OR:  aluResult = srcA | aluB;
			// signed compare
			cpuPkg::ALU_SLT: aluResult = {31'b0, $signed(srcA) < $signed(aluB)};
			cpuPkg::ALU_LUI: aluResult = aluB;
			// add and wrap
			default: aluResult = srcA + aluB;
		endcase
	end

	// rd for r-type, rt for immediate forms
	assign writeRegE = ctrlE.aluSrcImm ? rtE : ctrlE.writeReg;

	always_comb begin
		ctrlX = ctrlE;
		ctrlX.writeReg = writeRegE;
	end

	// to hazard unit
	assign hz.rsE = rsE;
	assign hz.rtE = rtE;
	assign hz.writeRegE = writeRegE;
	assign hz.regWriteE = ctrlE.regWrite;
	assign hz.memToRegE = ctrlE.memToReg;

	// execute/memory register
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrlM <= '0;
		end else begin
			ctrlM <= ctrlX;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM <= aluResult;
		storeDataM <= srcB;
		pcM <= pcE;
	end

endmodule

/* memWbStage.sv */
`timescale 1ns/1ns

module memWbStage (
	input logic clk,
	input logic reset,
	input cpuPkg::ctrl_t ctrlM,
	input cpuPkg::word_t aluOutM,
	input cpuPkg::word_t storeDataM,
	input cpuPkg::word_t pcM,
	input cpuPkg::word_t dataRdata,
	hazardIf.memWb hz,
	output cpuPkg::word_t dataAddr,
	output logic dataWe,
	output cpuPkg::word_t dataWdata,
	output cpuPkg::word_t resultW,
	output logic regWriteW,
	output cpuPkg::regAddr_t writeRegW,
	output logic retireValid,
	output cpuPkg::word_t retirePc,
	output cpuPkg::regAddr_t retireReg,
	output cpuPkg::word_t retireData
);

	logic validW, memToRegW, writesReg;
	cpuPkg::word_t aluOutW, readDataW, pcW;

	// data port, combinational memory
	assign dataAddr = aluOutM;
	assign dataWe = ctrlM.memWrite;
	assign dataWdata = storeDataM;

	assign hz.writeRegM = ctrlM.writeReg;
	assign hz.regWriteM = ctrlM.regWrite;
	assign hz.memToRegM = ctrlM.memToReg;

	// memory/writeback register
	always_ff @(posedge clk) begin
		if (reset) begin
			validW <= 1'b0;
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			writeRegW <= '0;
		end else begin
			validW <= ctrlM.valid;
			regWriteW <= ctrlM.regWrite;
			memToRegW <= ctrlM.memToReg;
			writeRegW <= ctrlM.writeReg;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW <= aluOutM;
		readDataW <= dataRdata;
		pcW <= pcM;
	end

	assign resultW = memToRegW ? readDataW : aluOutW;
	assign hz.writeRegW = writeRegW;
	assign hz.regWriteW = regWriteW;

	// retire report, r0 writes count as no write
	assign writesReg = regWriteW && writeRegW != 5'd0;
	assign retireValid = validW;
	assign retirePc = pcW;
	assign retireReg = writesReg ? writeRegW : 5'd0;
	assign retireData = writesReg ? resultW : '0;

endmodule

/* hazardUnit.sv */
`timescale 1ns/1ns

module hazardUnit (
	hazardIf.hazard hz
);

	logic lwStall, branchStall, eHitsD, mHitsD;

	// source matches a live, nonzero destination
	function automatic logic hits(
		input cpuPkg::regAddr_t src,
		input cpuPkg::regAddr_t dest,
		input logic en
	);
		return en && (dest != 5'd0) && (dest == src);
	endfunction

	// ==================================================
	// forwarding
	// ==================================================
	// memory stage is younger, so it wins
	assign hz.forwardAE = hits(hz.rsE, hz.writeRegM, hz.regWriteM) ? cpuPkg::FWD_MEM :
		hits(hz.rsE, hz.writeRegW, hz.regWriteW) ? cpuPkg::FWD_WB : cpuPkg::FWD_REGFILE;
	assign hz.forwardBE = hits(hz.rtE, hz.writeRegM, hz.regWriteM) ? cpuPkg::FWD_MEM :
		hits(hz.rtE, hz.writeRegW, hz.regWriteW) ? cpuPkg::FWD_WB : cpuPkg::FWD_REGFILE;

	// decode only needs memory, writeback goes through the regfile
	assign hz.forwardAD = hits(hz.rsD, hz.writeRegM, hz.regWriteM);
	assign hz.forwardBD = hits(hz.rtD, hz.writeRegM, hz.regWriteM);

	// ==================================================
	// stalls
	// ==================================================
	assign eHitsD = hits(hz.rsD, hz.writeRegE, hz.regWriteE) ||
		hits(hz.rtD, hz.writeRegE, hz.regWriteE);
	assign mHitsD = hits(hz.rsD, hz.writeRegM, hz.regWriteM) ||
		hits(hz.rtD, hz.writeRegM, hz.regWriteM);

	// load in execute feeding decode
	assign lwStall = hz.memToRegE && eHitsD;
	// branch waits for any execute result, and for a load still in memory
	assign branchStall = hz.branchD && (eHitsD || (hz.memToRegM && mHitsD));

	assign hz.stallF = lwStall || branchStall;
	assign hz.stallD = lwStall || branchStall;
	assign hz.flushE = lwStall || branchStall;

endmodule

/* mipsCore.sv */
`timescale 1ns/1ns

module mipsCore #(
	parameter cpuPkg::word_t resetVector = 32'h0
) (
	input logic clk,
	input logic reset,
	output cpuPkg::word_t instrAddr,
	input cpuPkg::word_t instr,
	output cpuPkg::word_t dataAddr,
	output logic dataWe,
	output cpuPkg::word_t dataWdata,
	input cpuPkg::word_t dataRdata,
	output logic retireValid,
	output cpuPkg::word_t retirePc,
	output cpuPkg::regAddr_t retireReg,
	output cpuPkg::word_t retireData
);

	// fetch to decode
	cpuPkg::word_t instrD, pcD, pcPlus4D, branchTarget;
	logic branchTaken;
	// decode to execute
	cpuPkg::ctrl_t ctrlE, ctrlM;
	cpuPkg::word_t srcAE, srcBE, immE, pcE;
	cpuPkg::regAddr_t rsE, rtE;
	// execute to memory
	cpuPkg::word_t aluOutM, storeDataM, pcM;
	// writeback back up the pipe
	cpuPkg::word_t resultW;
	logic regWriteW;
	cpuPkg::regAddr_t writeRegW;

	hazardIf hz ();

	fetchStage #(.resetVector(resetVector)) i_fetchStage (.clk(clk), .reset(reset),
		.instr(instr), .branchTaken(branchTaken), .branchTarget(branchTarget), .hz(hz),
		.instrAddr(instrAddr), .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D));

	decodeStage i_decodeStage (.clk(clk), .reset(reset), .instrD(instrD), .pcD(pcD),
		.pcPlus4D(pcPlus4D), .aluOutM(aluOutM), .resultW(resultW), .regWriteW(regWriteW),
		.writeRegW(writeRegW), .hz(hz), .branchTaken(branchTaken), .branchTarget(branchTarget),
		.ctrlE(ctrlE), .srcAE(srcAE), .srcBE(srcBE), .immE(immE), .pcE(pcE), .rsE(rsE),
		.rtE(rtE));

	executeStage i_executeStage (.clk(clk), .reset(reset), .ctrlE(ctrlE), .srcAE(srcAE),
		.srcBE(srcBE), .immE(immE), .pcE(pcE), .rsE(rsE), .rtE(rtE), .resultW(resultW),
		.hz(hz), .ctrlM(ctrlM), .aluOutM(aluOutM), .storeDataM(storeDataM), .pcM(pcM));

	memWbStage i_memWbStage (.clk(clk), .reset(reset), .ctrlM(ctrlM), .aluOutM(aluOutM),
		.storeDataM(storeDataM), .pcM(pcM), .dataRdata(dataRdata), .hz(hz),
		.dataAddr(dataAddr), .dataWe(dataWe), .dataWdata(dataWdata), .resultW(resultW),
		.regWriteW(regWriteW), .writeRegW(writeRegW), .retireValid(retireValid),
		.retirePc(retirePc), .retireReg(retireReg), .retireData(retireData));

	hazardUnit i_hazardUnit (.hz(hz));

endmodule

/* tb_mipsCore.sv */
`timescale 1ns/1ns

module tb_mipsCore;

	localparam cpuPkg::word_t resetVector = 32'h0000_0100;
	// word index of the first program word
	localparam int progBase = 64;

	logic clk = 1'b0;
	logic reset;
	cpuPkg::word_t instrAddr, instr, dataAddr, dataWdata, dataRdata;
	logic dataWe;
	logic retireValid;
	cpuPkg::word_t retirePc, retireData;
	cpuPkg::regAddr_t retireReg;

	// 256-word memories indexed by byte address bits 9:2
	cpuPkg::word_t imem [256];
	cpuPkg::word_t dmem [256];
	cpuPkg::word_t modelMem [256];
	cpuPkg::word_t prog [$];
	// expected retires in program order
	cpuPkg::word_t expPc [$];
	cpuPkg::regAddr_t expReg [$];
	cpuPkg::word_t expData [$];
	logic [15:0] lfsr;

	mipsCore #(.resetVector(resetVector)) i_mipsCore (.clk(clk), .reset(reset),
		.instrAddr(instrAddr), .instr(instr), .dataAddr(dataAddr), .dataWe(dataWe),
		.dataWdata(dataWdata), .dataRdata(dataRdata), .retireValid(retireValid),
		.retirePc(retirePc), .retireReg(retireReg), .retireData(retireData));

	always #50 clk = ~clk;

	// ==================================================
	// memory models
	// ==================================================
	assign instr = imem[instrAddr[9:2]];
	assign dataRdata = dmem[dataAddr[9:2]];

	// unused code words hold an unknown opcode tagged with the address
	function automatic cpuPkg::word_t noOpFill(input int idx);
		return {6'h3f, 16'h0, 8'(idx), 2'b00};
	endfunction

	function automatic cpuPkg::word_t dataFill(input int idx);
		return {8'(idx), 8'(255 - idx), 8'(idx * 7), 8'hc3};
	endfunction

	// back to the fill pattern while the core is held in reset
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= dataFill(i);
			end
		end else if (dataWe) begin
			dmem[dataAddr[9:2]] <= dataWdata;
		end
	end

	// ==================================================
	// encoders and random source
	// ==================================================
	function automatic cpuPkg::word_t rOp(input cpuPkg::funct_e fn, input int rd, input int rs,
		input int rt);
		return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
	endfunction

	// arguments in assembly order with rt before rs
	function automatic cpuPkg::word_t iOp(input cpuPkg::opcode_e op, input int rt, input int rs,
		input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	// galois step with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsrNext(lfsr);
		end
	endtask

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic checkWord(input string name, input cpuPkg::word_t expected,
		input cpuPkg::word_t actual);
		if (actual !== expected) begin
			$display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic checkReg(input string name, input cpuPkg::regAddr_t expected,
		input cpuPkg::regAddr_t actual);
		if (actual !== expected) begin
			$display("Error at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "register number mismatch");
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error at time %0t: %s expected %b, got %b", $time, name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "bit mismatch");
		end
	endtask

	// ==================================================
	// sequential isa model stepping one instruction at a time
	// ==================================================
	task automatic modelRun;
		cpuPkg::word_t regs [32];
		cpuPkg::word_t pc, npc, ins, a, b, imm, res, addr, progEnd;
		cpuPkg::regAddr_t dest;
		logic taken;
		int steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			modelMem[i] = dataFill(i);
		end
		expPc = {};
		expReg = {};
		expData = {};
		progEnd = resetVector + 32'(4 * prog.size());
		pc = resetVector;
		npc = resetVector + 32'd4;
		steps = 0;
		while (pc >= resetVector && pc < progEnd && steps < 1000) begin
			ins = imem[pc[9:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			dest = 5'd0;
			res = '0;
			taken = 1'b0;
			case (ins[31:26])
				cpuPkg::OP_SPECIAL: begin
					dest = ins[15:11];
					case (ins[5:0])
						cpuPkg::FN_ADDU: res = a + b;
						cpuPkg::FN_SUBU: res = a - b;
						cpuPkg::FN_AND: res = a & b;
						cpuPkg::FN_OR: res = a | b;
						cpuPkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: dest = 5'd0;
					endcase
				end
				cpuPkg::OP_ADDIU: begin
					dest = ins[20:16];
					res = a + imm;
				end
				cpuPkg::OP_ORI: begin
					dest = ins[20:16];
					res = a | {16'h0, ins[15:0]};
				end
				cpuPkg::OP_LUI: begin
					dest = ins[20:16];
					res = {ins[15:0], 16'h0};
				end
				cpuPkg::OP_LW: begin
					dest = ins[20:16];
					addr = a + imm;
					res = modelMem[addr[9:2]];
				end
				cpuPkg::OP_SW: begin
					addr = a + imm;
					modelMem[addr[9:2]] = b;
				end
				cpuPkg::OP_BEQ: taken = (a == b);
				cpuPkg::OP_BNE: taken = (a != b);
				default: ;
			endcase
			// r0 writes report as no write
			if (dest == 5'd0) begin
				res = '0;
			end else begin
				regs[dest] = res;
			end
			expPc.push_back(pc);
			expReg.push_back(dest);
			expData.push_back(res);
			// delay slot runs before the target
			addr = npc;
			npc = taken ? (pc + 32'd4 + (imm << 2)) : (npc + 32'd4);
			pc = addr;
			steps++;
		end
	endtask

	// ==================================================
	// run helpers
	// ==================================================
	task automatic loadProgram;
		for (int i = 0; i < 256; i++) begin
			imem[i] = noOpFill(i);
		end
		foreach (prog[i]) begin
			imem[progBase + i] = prog[i];
		end
	endtask

	// 8 reset cycles with quiet outputs and pc at the vector
	task automatic applyReset;
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			if (i == 7) begin
				reset <= 1'b0;
			end
			@(negedge clk);
			checkBit("retireValid", 1'b0, retireValid);
			checkBit("dataWe", 1'b0, dataWe);
			checkWord("instrAddr", resetVector, instrAddr);
		end
	endtask

	task automatic runProgram(input string name);
		int cycles;
		int limit;
		cpuPkg::word_t pcExp, dataExp;
		cpuPkg::regAddr_t regExp;
		loadProgram();
		modelRun();
		applyReset();
		// 6 cycles per instruction plus pipeline fill
		limit = 6 * prog.size() + 50;
		cycles = 0;
		while (expPc.size() > 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: %s still waits for %0d retires after %0d cycles", name,
					expPc.size(), limit);
				$display("Simulation FAILED");
				$fatal(1, "timeout");
			end
			if (retireValid) begin
				pcExp = expPc.pop_front();
				regExp = expReg.pop_front();
				dataExp = expData.pop_front();
				checkWord("retirePc", pcExp, retirePc);
				checkReg("retireReg", regExp, retireReg);
				checkWord("retireData", dataExp, retireData);
			end
		end
		// stores have all written by the last retire
		for (int i = 0; i < 256; i++) begin
			checkWord($sformatf("dmem[%0d]", i), modelMem[i], dmem[i]);
		end
		$display("%s: all retires and memory words match", name);
	endtask

	// ==================================================
	// directed tests
	// ==================================================
	// dependent chain forwarding from memory and writeback stages
	task automatic testAluChain;
		prog = {};
		prog.push_back(iOp(cpuPkg::OP_LUI, 1, 0, 'h1234));
		prog.push_back(iOp(cpuPkg::OP_ORI, 1, 1, 'h5678));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 2, 0, -5));
		prog.push_back(rOp(cpuPkg::FN_ADDU, 3, 1, 2));
		prog.push_back(rOp(cpuPkg::FN_SUBU, 4, 3, 1));
		prog.push_back(rOp(cpuPkg::FN_AND, 5, 4, 3));
		prog.push_back(rOp(cpuPkg::FN_OR, 6, 5, 2));
		// signed compare both ways
		prog.push_back(rOp(cpuPkg::FN_SLT, 7, 4, 0));
		prog.push_back(rOp(cpuPkg::FN_SLT, 8, 0, 4));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 9, 7, 'h7fff));
		// write to r0 is dropped
		prog.push_back(rOp(cpuPkg::FN_ADDU, 0, 9, 9));
		prog.push_back(rOp(cpuPkg::FN_ADDU, 10, 0, 9));
		runProgram("alu chain");
	endtask

	task automatic testLoadStore;
		prog = {};
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 1, 0, 'h40));
		prog.push_back(iOp(cpuPkg::OP_LUI, 2, 0, 'hcafe));
		prog.push_back(iOp(cpuPkg::OP_ORI, 2, 2, 'hbeef));
		// store data forwarded from memory stage
		prog.push_back(iOp(cpuPkg::OP_SW, 2, 1, 0));
		prog.push_back(iOp(cpuPkg::OP_SW, 1, 1, 4));
		// load then direct user
		prog.push_back(iOp(cpuPkg::OP_LW, 3, 1, 0));
		prog.push_back(rOp(cpuPkg::FN_ADDU, 4, 3, 3));
		prog.push_back(iOp(cpuPkg::OP_LW, 5, 1, 4));
		prog.push_back(iOp(cpuPkg::OP_SW, 5, 1, 8));
		// untouched word still holds the fill pattern
		prog.push_back(iOp(cpuPkg::OP_LW, 6, 1, 12));
		prog.push_back(rOp(cpuPkg::FN_SUBU, 7, 6, 4));
		prog.push_back(iOp(cpuPkg::OP_SW, 7, 1, 16));
		runProgram("load store");
	endtask

	task automatic testBranches;
		prog = {};
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 1, 0, 3));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 2, 0, 3));
		// taken beq with r2 still in execute
		prog.push_back(iOp(cpuPkg::OP_BEQ, 2, 1, 2));
		// delay slot result feeds the next branch
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 3, 0, 3));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 4, 0, 'h44));
		// untaken bne with r3 still in execute
		prog.push_back(iOp(cpuPkg::OP_BNE, 1, 3, 2));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 5, 0, 7));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 6, 0, 'h80));
		prog.push_back(iOp(cpuPkg::OP_SW, 5, 6, 0));
		prog.push_back(iOp(cpuPkg::OP_LW, 7, 6, 0));
		// taken bne on a fresh load against r0
		prog.push_back(iOp(cpuPkg::OP_BNE, 0, 7, 2));
		prog.push_back(rOp(cpuPkg::FN_ADDU, 8, 7, 1));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 9, 0, 'h99));
		prog.push_back(iOp(cpuPkg::OP_LW, 10, 6, 0));
		// untaken beq on a fresh load against its own address
		prog.push_back(iOp(cpuPkg::OP_BEQ, 6, 10, 2));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 11, 10, 1));
		prog.push_back(iOp(cpuPkg::OP_ADDIU, 12, 0, 2));
		prog.push_back(rOp(cpuPkg::FN_SUBU, 13, 12, 11));
		runProgram("branches");
	endtask

	// 40 alu and immediate ops over r0 to r7
	task automatic testRandom;
		logic [31:0] kind, rd, rs, rt, imm;
		prog = {};
		lfsr = 16'd95;
		repeat (40) begin
			drawBits(3, kind);
			drawBits(3, rd);
			drawBits(3, rs);
			drawBits(3, rt);
			drawBits(16, imm);
			case (kind)
				0: prog.push_back(rOp(cpuPkg::FN_ADDU, rd, rs, rt));
				1: prog.push_back(rOp(cpuPkg::FN_SUBU, rd, rs, rt));
				2: prog.push_back(rOp(cpuPkg::FN_AND, rd, rs, rt));
				3: prog.push_back(rOp(cpuPkg::FN_OR, rd, rs, rt));
				4: prog.push_back(rOp(cpuPkg::FN_SLT, rd, rs, rt));
				5: prog.push_back(iOp(cpuPkg::OP_ADDIU, rt, rs, imm));
				6: prog.push_back(iOp(cpuPkg::OP_ORI, rt, rs, imm));
				default: prog.push_back(iOp(cpuPkg::OP_LUI, rt, 0, imm));
			endcase
		end
		runProgram("random alu");
	endtask

	initial begin
		reset <= 1'b1;
		testAluChain();
		testLoadStore();
		testBranches();
		testRandom();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* mipsCore.f */
cpuPkg.sv
hazardIf.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
hazardUnit.sv
mipsCore.sv
tb_mipsCore.sv

/* Makefile */
TOP = tb_mipsCore

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f mipsCore.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
